// File: hw/static_cfg.svh
`ifndef STATIC_CFG_SVH
`define STATIC_CFG_SVH

// ----------------------------------------------------------------------
// Bus and DMA widths
// ----------------------------------------------------------------------
`define AXIL_DATA_BITS 64
`define AXIL_ADDR_BITS 7       // 16 registers of 8 bytes
`define ADDR_LSB       3       // Byte offset inside a word
`define PADDR_BITS     48
`define LEN_BITS       28

`define PR_QDEPTH      16      // PR request queue entries

// Probe and configuration values
`define PROBE_ID       64'h0000_0000_5EA1_C0DE
`define N_CHAN_VAL     3
`define N_REGIONS_VAL  1

// ----------------------------------------------------------------------
// Register map (word indices)
// ----------------------------------------------------------------------
`define PROBE_REG      0
`define N_CHAN_REG     1
`define N_REGIONS_REG  2
`define LOWSPEED_REG   8
`define PR_CTRL_REG    10      // Self clearing
`define PR_STAT_REG    11
`define PR_ADDR_REG    12
`define PR_LEN_REG     13

`define LOWSPEED_RST   6'h3F

`endif

// File: hw/static_pkg.sv
`default_nettype none

`include "static_cfg.svh"

package static_pkg;

  // Register word, seen either raw or as PR control fields
  typedef union packed {
    logic [`AXIL_DATA_BITS-1:0] raw;
    struct packed {
      logic [`AXIL_DATA_BITS-4:0] rsvd;
      logic clr;    // Clear sticky done
      logic ctl;
      logic start;
    } f;
  } pr_ctrl_u;

endpackage

`default_nettype wire

// File: hw/pr_req_if.sv
`timescale 1ns/1ns
`default_nettype none

`include "static_cfg.svh"

// One PR DMA read request, valid/ready handshake
interface pr_req_if;
  logic                   valid;
  logic                   ready;
  logic                   ctl;
  logic [`PADDR_BITS-1:0] paddr;
  logic [`LEN_BITS-1:0]   len;

  modport src (
    output valid, ctl, paddr, len,
    input  ready
  );

  modport snk (
    input  valid, ctl, paddr, len,
    output ready
  );
endinterface

`default_nettype wire

// File: hw/cnfg_regfile.sv
`timescale 1ns/1ns
`default_nettype none

`include "static_cfg.svh"

module cnfg_regfile (
  input  logic                        aclk,
  input  logic                        aresetn,
  input  logic                        dma_done,

  input  logic [`AXIL_ADDR_BITS-1:0]  awaddr,
  input  logic                        awvalid,
  output logic                        awready,
  input  logic [`AXIL_DATA_BITS-1:0]  wdata,
  input  logic [`AXIL_DATA_BITS/8-1:0] wstrb,
  input  logic                        wvalid,
  output logic                        wready,
  output logic [1:0]                  bresp,
  output logic                        bvalid,
  input  logic                        bready,
  input  logic [`AXIL_ADDR_BITS-1:0]  araddr,
  input  logic                        arvalid,
  output logic                        arready,
  output logic [`AXIL_DATA_BITS-1:0]  rdata,
  output logic [1:0]                  rresp,
  output logic                        rvalid,
  input  logic                        rready,

  output logic [5:0]                  lowspeed_ctrl,
  pr_req_if.src                       prod
);

  localparam int IDX_BITS = `AXIL_ADDR_BITS - `ADDR_LSB;

  logic [IDX_BITS-1:0]        aw_idx_q;
  logic [IDX_BITS-1:0]        ar_idx_q;
  logic                       aw_en_q;     // Low while a write response is pending
  logic                       wr_en;
  logic                       rd_en;
  logic [`AXIL_DATA_BITS-1:0] rd_word;

  static_pkg::pr_ctrl_u       wr_word;

  logic [5:0]                 lowspeed_q;
  logic [`AXIL_DATA_BITS-1:0] pr_addr_q;
  logic [31:0]                pr_len_q;
  logic                       pr_ctl_q;
  logic                       pr_start_q;  // One cycle request strobe
  logic                       pr_clr_q;
  logic                       pr_done_q;

  assign wr_word.raw = wdata;

  // ----------------------------------------------------------------------
  // AXI4-Lite handshake
  // ----------------------------------------------------------------------
  assign wr_en = awready && awvalid && wready && wvalid;
  assign rd_en = arready && arvalid && !rvalid;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      awready <= 1'b0;
      wready  <= 1'b0;
      aw_en_q <= 1'b1;
      bvalid  <= 1'b0;
      arready <= 1'b0;
      rvalid  <= 1'b0;
    end else begin
      awready <= 1'b0;
      wready  <= 1'b0;
      arready <= 1'b0;
      if (!awready && awvalid && wvalid && aw_en_q) begin
        awready <= 1'b1;
        wready  <= 1'b1;
        aw_en_q <= 1'b0;
      end else if (bvalid && bready) begin
        aw_en_q <= 1'b1;
      end
      if (wr_en)
        bvalid <= 1'b1;
      else if (bready)
        bvalid <= 1'b0;
      if (!arready && arvalid && !rvalid)
        arready <= 1'b1;
      if (rd_en)
        rvalid <= 1'b1;
      else if (rready)
        rvalid <= 1'b0;
    end
  end

  always_ff @(posedge aclk) begin
    if (!awready && awvalid && wvalid && aw_en_q)
      aw_idx_q <= awaddr[`AXIL_ADDR_BITS-1:`ADDR_LSB];
    if (!arready && arvalid)
      ar_idx_q <= araddr[`AXIL_ADDR_BITS-1:`ADDR_LSB];
    if (rd_en)
      rdata <= rd_word;
  end

  assign bresp = 2'b00;  // Always OKAY
  assign rresp = 2'b00;

  // ----------------------------------------------------------------------
  // Register writes
  // ----------------------------------------------------------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      lowspeed_q <= `LOWSPEED_RST;
      pr_start_q <= 1'b0;
      pr_clr_q   <= 1'b0;
      pr_done_q  <= 1'b0;
    end else begin
      pr_start_q <= 1'b0;
      pr_clr_q   <= 1'b0;
      // Clear has priority over a new done
      pr_done_q  <= pr_clr_q ? 1'b0 : (dma_done ? 1'b1 : pr_done_q);
      if (wr_en && wstrb[0]) begin
        if (aw_idx_q == IDX_BITS'(`LOWSPEED_REG))
          lowspeed_q <= wr_word.raw[5:0];
        if (aw_idx_q == IDX_BITS'(`PR_CTRL_REG)) begin
          pr_start_q <= wr_word.f.start;
          pr_clr_q   <= wr_word.f.clr;
        end
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (wr_en) begin
      case (aw_idx_q)
        IDX_BITS'(`PR_CTRL_REG):
          if (wstrb[0]) pr_ctl_q <= wr_word.f.ctl;
        IDX_BITS'(`PR_ADDR_REG):
          for (int i = 0; i < `AXIL_DATA_BITS/8; i++) begin
            if (wstrb[i]) pr_addr_q[i*8 +: 8] <= wr_word.raw[i*8 +: 8];
          end
        IDX_BITS'(`PR_LEN_REG):
          for (int i = 0; i < 4; i++) begin  // Lower word only
            if (wstrb[i]) pr_len_q[i*8 +: 8] <= wr_word.raw[i*8 +: 8];
          end
        default: ;
      endcase
    end
  end

  // ----------------------------------------------------------------------
  // Read mux
  // ----------------------------------------------------------------------
  always_comb begin
    rd_word = '0;
    case (ar_idx_q)
      IDX_BITS'(`PROBE_REG):     rd_word = `PROBE_ID;
      IDX_BITS'(`N_CHAN_REG):    rd_word = `AXIL_DATA_BITS'(`N_CHAN_VAL);
      IDX_BITS'(`N_REGIONS_REG): rd_word = `AXIL_DATA_BITS'(`N_REGIONS_VAL);
      IDX_BITS'(`LOWSPEED_REG):  rd_word[5:0] = lowspeed_q;
      IDX_BITS'(`PR_STAT_REG):   rd_word[1:0] = {prod.ready, pr_done_q};
      IDX_BITS'(`PR_ADDR_REG):   rd_word = pr_addr_q;
      IDX_BITS'(`PR_LEN_REG):    rd_word[31:0] = pr_len_q;
      default: ;                 // Control and unmapped read zero
    endcase
  end

  // Request towards the queue
  assign prod.valid = pr_start_q;
  assign prod.ctl   = pr_ctl_q;
  assign prod.paddr = pr_addr_q[`PADDR_BITS-1:0];
  assign prod.len   = pr_len_q[`LEN_BITS-1:0];

  assign lowspeed_ctrl = lowspeed_q;

endmodule

`default_nettype wire

// File: hw/pr_req_queue.sv
`timescale 1ns/1ns
`default_nettype none

`include "static_cfg.svh"

// Circular FIFO of PR requests, DEPTH is a power of two of at least 2
module pr_req_queue #(
  parameter int DEPTH = `PR_QDEPTH
) (
  input  logic  aclk,
  input  logic  aresetn,
  pr_req_if.snk in,
  pr_req_if.src out
);

  localparam int EW = 1 + `PADDR_BITS + `LEN_BITS;  // {ctl, paddr, len}
  localparam int PW = $clog2(DEPTH);
  localparam int CW = PW + 1;

  logic [EW-1:0] mem [0:DEPTH-1];
  logic [PW-1:0] wr_ptr_q;
  logic [PW-1:0] rd_ptr_q;
  logic [CW-1:0] count_q;
  logic          push;
  logic          pop;

  assign in.ready  = (count_q != CW'(DEPTH));
  assign out.valid = (count_q != '0);

  assign push = in.valid && in.ready;
  assign pop  = out.valid && out.ready;

  always_ff @(posedge aclk) begin
    if (push)
      mem[wr_ptr_q] <= {in.ctl, in.paddr, in.len};
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= wr_ptr_q + 1'b1;  // Wraps at DEPTH
      if (pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: ;
      endcase
    end
  end

  // Head of queue
  assign {out.ctl, out.paddr, out.len} = mem[rd_ptr_q];

endmodule

`default_nettype wire

// File: hw/pr_dma_issuer.sv
`timescale 1ns/1ns
`default_nettype none

`include "static_cfg.svh"

module pr_dma_issuer (
  input  logic                   aclk,
  input  logic                   aresetn,
  pr_req_if.snk                  in,
  output logic                   dma_req,
  input  logic                   dma_ack,
  output logic                   dma_ctl,
  output logic [`PADDR_BITS-1:0] dma_paddr,
  output logic [`LEN_BITS-1:0]   dma_len
);

  localparam logic [1:0] S_IDLE    = 2'd0;
  localparam logic [1:0] S_REQ     = 2'd1;  // Request held until ack
  localparam logic [1:0] S_ACK_LOW = 2'd2;  // Wait for ack to drop

  logic [1:0] state_q;

  assign in.ready = (state_q == S_IDLE);
  assign dma_req  = (state_q == S_REQ);

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state_q <= S_IDLE;
    end else begin
      case (state_q)
        S_IDLE:    if (in.valid) state_q <= S_REQ;
        S_REQ:     if (dma_ack) state_q <= S_ACK_LOW;
        S_ACK_LOW: if (!dma_ack) state_q <= S_IDLE;
        default:   state_q <= S_IDLE;
      endcase
    end
  end

  // Payload latched on accept, stable for the whole handshake
  always_ff @(posedge aclk) begin
    if (in.valid && in.ready) begin
      dma_ctl   <= in.ctl;
      dma_paddr <= in.paddr;
      dma_len   <= in.len;
    end
  end

endmodule

`default_nettype wire

// File: hw/static_slave_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "static_cfg.svh"

module static_slave_top (
  input  logic                         aclk,
  input  logic                         aresetn,

  // Host control bus
  input  logic [`AXIL_ADDR_BITS-1:0]   axil_awaddr,
  input  logic                         axil_awvalid,
  output logic                         axil_awready,
  input  logic [`AXIL_DATA_BITS-1:0]   axil_wdata,
  input  logic [`AXIL_DATA_BITS/8-1:0] axil_wstrb,
  input  logic                         axil_wvalid,
  output logic                         axil_wready,
  output logic [1:0]                   axil_bresp,
  output logic                         axil_bvalid,
  input  logic                         axil_bready,
  input  logic [`AXIL_ADDR_BITS-1:0]   axil_araddr,
  input  logic                         axil_arvalid,
  output logic                         axil_arready,
  output logic [`AXIL_DATA_BITS-1:0]   axil_rdata,
  output logic [1:0]                   axil_rresp,
  output logic                         axil_rvalid,
  input  logic                         axil_rready,

  // PR DMA engine
  output logic                         dma_req,
  input  logic                         dma_ack,
  output logic                         dma_ctl,
  output logic [`PADDR_BITS-1:0]       dma_paddr,
  output logic [`LEN_BITS-1:0]         dma_len,
  input  logic                         dma_done,

  output logic [2:0]                   lowspeed_ctrl_0,
  output logic [2:0]                   lowspeed_ctrl_1
);

  logic [5:0] lowspeed_ctrl;

  pr_req_if prod ();
  pr_req_if issue ();

  cnfg_regfile inst_regfile (
    .aclk(aclk), .aresetn(aresetn), .dma_done(dma_done),
    .awaddr(axil_awaddr), .awvalid(axil_awvalid), .awready(axil_awready),
    .wdata(axil_wdata), .wstrb(axil_wstrb), .wvalid(axil_wvalid), .wready(axil_wready),
    .bresp(axil_bresp), .bvalid(axil_bvalid), .bready(axil_bready),
    .araddr(axil_araddr), .arvalid(axil_arvalid), .arready(axil_arready),
    .rdata(axil_rdata), .rresp(axil_rresp), .rvalid(axil_rvalid), .rready(axil_rready),
    .lowspeed_ctrl(lowspeed_ctrl), .prod(prod)
  );

  pr_req_queue #(.DEPTH(`PR_QDEPTH)) inst_queue (
    .aclk(aclk), .aresetn(aresetn), .in(prod), .out(issue)
  );

  pr_dma_issuer inst_issuer (
    .aclk(aclk), .aresetn(aresetn), .in(issue),
    .dma_req(dma_req), .dma_ack(dma_ack), .dma_ctl(dma_ctl),
    .dma_paddr(dma_paddr), .dma_len(dma_len)
  );

  assign lowspeed_ctrl_0 = lowspeed_ctrl[2:0];  // Both ports share the low bits
  assign lowspeed_ctrl_1 = lowspeed_ctrl[2:0];

endmodule

`default_nettype wire

// File: verification/tb_static_slave.sv
`timescale 1ns/1ns
`default_nettype none

`include "static_cfg.svh"

module tb_static_slave;

  localparam int MAX_OPS  = 64;
  localparam int REQ_BITS = 1 + `PADDR_BITS + `LEN_BITS;  // {ctl, paddr, len}

  logic                         aclk;
  logic                         aresetn;
  logic [`AXIL_ADDR_BITS-1:0]   axil_awaddr;
  logic                         axil_awvalid;
  logic                         axil_awready;
  logic [`AXIL_DATA_BITS-1:0]   axil_wdata;
  logic [`AXIL_DATA_BITS/8-1:0] axil_wstrb;
  logic                         axil_wvalid;
  logic                         axil_wready;
  logic [1:0]                   axil_bresp;
  logic                         axil_bvalid;
  logic                         axil_bready;
  logic [`AXIL_ADDR_BITS-1:0]   axil_araddr;
  logic                         axil_arvalid;
  logic                         axil_arready;
  logic [`AXIL_DATA_BITS-1:0]   axil_rdata;
  logic [1:0]                   axil_rresp;
  logic                         axil_rvalid;
  logic                         axil_rready;
  logic                         dma_req;
  logic                         dma_ack = 1'b0;
  logic                         dma_ctl;
  logic [`PADDR_BITS-1:0]       dma_paddr;
  logic [`LEN_BITS-1:0]         dma_len;
  logic                         dma_done;
  logic [2:0]                   lowspeed_ctrl_0;
  logic [2:0]                   lowspeed_ctrl_1;

  logic [63:0]         stim [0:4*MAX_OPS-1];  // Four words per line
  logic [REQ_BITS-1:0] exp_q [$];
  logic [REQ_BITS-1:0] held_req;
  logic                req_seen = 1'b0;
  logic                hold_ack;
  logic                delay_armed = 1'b0;
  logic [31:0]         rng_state = 32'd65232;
  int                  ack_delay = 0;
  int                  cycle_count = 0;
  int                  cycle_limit = 0;  // Zero until the stimulus is loaded
  int                  n_ops;

  static_slave_top uut (
    .aclk(aclk), .aresetn(aresetn),
    .axil_awaddr(axil_awaddr), .axil_awvalid(axil_awvalid), .axil_awready(axil_awready),
    .axil_wdata(axil_wdata), .axil_wstrb(axil_wstrb), .axil_wvalid(axil_wvalid),
    .axil_wready(axil_wready), .axil_bresp(axil_bresp), .axil_bvalid(axil_bvalid),
    .axil_bready(axil_bready), .axil_araddr(axil_araddr), .axil_arvalid(axil_arvalid),
    .axil_arready(axil_arready), .axil_rdata(axil_rdata), .axil_rresp(axil_rresp),
    .axil_rvalid(axil_rvalid), .axil_rready(axil_rready),
    .dma_req(dma_req), .dma_ack(dma_ack), .dma_ctl(dma_ctl), .dma_paddr(dma_paddr),
    .dma_len(dma_len), .dma_done(dma_done),
    .lowspeed_ctrl_0(lowspeed_ctrl_0), .lowspeed_ctrl_1(lowspeed_ctrl_1)
  );

  initial begin
    aclk = 1'b0;
    forever #20 aclk = ~aclk;
  end

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Test failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp)
      abort_run($sformatf("MISMATCH at %0t ns: %s got %h expected %h", $time, what, got, exp));
  endtask

  task automatic compare_request(input logic [REQ_BITS-1:0] exp, input string what);
    check_value(64'(dma_ctl), 64'(exp[REQ_BITS-1]), {what, " ctl"});
    check_value(64'(dma_paddr), 64'(exp[`LEN_BITS +: `PADDR_BITS]), {what, " paddr"});
    check_value(64'(dma_len), 64'(exp[`LEN_BITS-1:0]), {what, " len"});
  endtask

  task automatic axil_write(input logic [3:0] idx, input logic [63:0] data,
                            input logic [7:0] strb);
    @(posedge aclk);
    axil_awaddr  <= {idx, 3'b000};
    axil_wdata   <= data;
    axil_wstrb   <= strb;
    axil_awvalid <= 1'b1;
    axil_wvalid  <= 1'b1;
    axil_bready  <= 1'b1;
    @(posedge aclk);
    while (!axil_awready) @(posedge aclk);
    check_value(64'(axil_wready), 64'd1, "wready alongside awready");
    axil_awvalid <= 1'b0;
    axil_wvalid  <= 1'b0;
    @(posedge aclk);
    while (!axil_bvalid) @(posedge aclk);
    check_value(64'(axil_bresp), 64'd0, "write response");  // OKAY
    axil_bready  <= 1'b0;
  endtask

  task automatic axil_read(input logic [3:0] idx, output logic [63:0] data);
    @(posedge aclk);
    axil_araddr  <= {idx, 3'b000};
    axil_arvalid <= 1'b1;
    axil_rready  <= 1'b1;
    @(posedge aclk);
    while (!axil_arready) @(posedge aclk);
    axil_arvalid <= 1'b0;
    @(posedge aclk);
    while (!axil_rvalid) @(posedge aclk);
    data = axil_rdata;
    check_value(64'(axil_rresp), 64'd0, "read response");  // OKAY
    axil_rready  <= 1'b0;
  endtask

  // Until every expected request has been issued and fully handshaken
  task automatic wait_idle();
    @(posedge aclk);
    while (exp_q.size() != 0 || dma_req || dma_ack) @(posedge aclk);
  endtask

  // ----------------------------------------------------------------------
  // DMA responder and request monitor
  // ----------------------------------------------------------------------
  always @(posedge aclk) begin
    if (!aresetn) begin
      dma_ack     <= 1'b0;
      delay_armed <= 1'b0;
    end else if (dma_ack) begin
      if (!dma_req) dma_ack <= 1'b0;  // Fourth phase
    end else if (dma_req && !hold_ack) begin
      if (!delay_armed) begin
        rng_state = xorshift32(rng_state);
        ack_delay   <= int'(rng_state % 32'd4);
        delay_armed <= 1'b1;
      end else if (ack_delay == 0) begin
        dma_ack     <= 1'b1;
        delay_armed <= 1'b0;
      end else begin
        ack_delay   <= ack_delay - 1;
      end
    end
  end

  always @(posedge aclk) begin
    if (!aresetn || !dma_req) begin
      req_seen <= 1'b0;
    end else if (!req_seen) begin
      req_seen <= 1'b1;
      held_req <= {dma_ctl, dma_paddr, dma_len};
      if (dma_ack)
        abort_run("DMA request raised while the previous ack was still high");
      else if (exp_q.size() == 0)
        abort_run($sformatf("Unexpected DMA request at %0t ns", $time));
      else
        compare_request(exp_q.pop_front(), "DMA request");
    end else begin
      compare_request(held_req, "DMA payload during handshake");
    end
  end

  always @(posedge aclk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit != 0 && cycle_count >= cycle_limit)
      abort_run($sformatf("Timeout after %0d clock cycles", cycle_count));
  end

  // ----------------------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------------------
  initial begin
    static_pkg::pr_ctrl_u ctrl_word;
    logic [63:0]          op;
    logic [63:0]          rd_val;
    int                   base;

    aresetn      = 1'b0;
    axil_awaddr  = '0;
    axil_awvalid = 1'b0;
    axil_wdata   = '0;
    axil_wstrb   = '0;
    axil_wvalid  = 1'b0;
    axil_bready  = 1'b0;
    axil_araddr  = '0;
    axil_arvalid = 1'b0;
    axil_rready  = 1'b0;
    dma_done     = 1'b0;
    hold_ack     = 1'b0;

    $readmemh("verification/stim_input.txt", stim);
    n_ops = 0;
    while (n_ops < MAX_OPS && stim[4*n_ops] != 64'hF) n_ops++;
    cycle_limit = 200 * (n_ops + 1);

    repeat (2) @(posedge aclk);
    aresetn <= 1'b1;

    for (int i = 0; i < n_ops; i++) begin
      base = 4 * i;
      op   = stim[base];
      case (op)
        64'h1: axil_write(stim[base+1][3:0], stim[base+2], stim[base+3][7:0]);
        64'h2: begin
          axil_read(stim[base+1][3:0], rd_val);
          check_value(rd_val, stim[base+2], $sformatf("read of register %0d", stim[base+1]));
        end
        64'h3: begin
          ctrl_word.raw     = '0;
          ctrl_word.f.start = stim[base+1][0];
          ctrl_word.f.ctl   = stim[base+2][0];
          ctrl_word.f.clr   = stim[base+3][0];
          axil_write(4'(`PR_CTRL_REG), ctrl_word.raw, 8'h01);
        end
        64'h4: exp_q.push_back({stim[base+1][0], stim[base+2][`PADDR_BITS-1:0],
                                stim[base+3][`LEN_BITS-1:0]});
        64'h5: begin
          @(posedge aclk);
          dma_done <= 1'b1;
          @(posedge aclk);
          dma_done <= 1'b0;
        end
        64'h6: begin
          @(posedge aclk);
          hold_ack <= 1'b1;
        end
        64'h7: begin
          @(posedge aclk);
          hold_ack <= 1'b0;
        end
        64'h8: begin
          @(posedge aclk);
          check_value(64'(lowspeed_ctrl_0), stim[base+1], "lowspeed_ctrl_0");
          check_value(64'(lowspeed_ctrl_1), stim[base+1], "lowspeed_ctrl_1");
        end
        64'h9: wait_idle();
        default: abort_run($sformatf("Unknown stimulus opcode %h on entry %0d", op, i));
      endcase
    end

    // Let any late request show up before the final check
    repeat (8) @(posedge aclk);
    while (dma_req || dma_ack) @(posedge aclk);
    if (exp_q.size() != 0) begin
      abort_run($sformatf("%0d expected DMA requests were never issued", exp_q.size()));
    end else begin
      $display("Test completed successfully");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: src.f
+incdir+hw
hw/static_pkg.sv
hw/pr_req_if.sv
hw/cnfg_regfile.sv
hw/pr_req_queue.sv
hw/pr_dma_issuer.sv
hw/static_slave_top.sv
verification/tb_static_slave.sv

// File: Makefile
TOP := tb_static_slave

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): src.f $(wildcard hw/*.sv hw/*.svh verification/*.sv)
	verilator --binary --timing -Wno-fatal -f src.f --top-module $(TOP) -o V$(TOP)

# The simulator exit status is the pass or fail result
run: obj_dir/V$(TOP) verification/stim_input.txt
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing -Wall -f src.f --top-module static_slave_top

clean:
	rm -rf obj_dir

// File: verification/stim_input.txt
// op a b c, hex. 1 write idx data strb, 2 read idx expect, 3 ctrl start ctl clr,
// 4 expect dma ctl paddr len, 5 done pulse, 6 hold ack, 7 release ack, 8 lowspeed out, 9 drain, F end
2 0 000000005EA1C0DE 0
2 1 3 0
2 2 1 0
2 5 0 0
1 5 FFFFFFFFFFFFFFFF FF
2 5 0 0
2 F 0 0
2 8 3F 0
8 7 0 0
1 8 00000000000000A5 01
2 8 25 0
8 5 0 0
1 8 FFFFFFFFFFFFFF00 FE
2 8 25 0
8 5 0 0
1 C ABCD001234567000 FF
1 D FFFFFFFF1F002000 FF
4 1 001234567000 F002000
3 1 1 0
9 0 0 0
2 A 0 0
2 D 1F002000 0
6 0 0 0
1 C 0000000000100000 FF
4 0 100000 F002000
3 1 0 0
2 B 2 0
1 C 0000000000200000 FF
4 1 200000 F002000
3 1 1 0
1 C 0000000000300000 FF
4 0 300000 F002000
3 1 0 0
2 B 2 0
7 0 0 0
9 0 0 0
5 0 0 0
2 B 3 0
3 0 0 0
2 B 3 0
3 0 0 1
2 B 2 0
F 0 0 0
